// File: Bender.yml
package:
  name: jtag2_tap

sources:
  # RTL in compile order
  - jtag2_pkg.sv
  - jtag2_ctrl_if.sv
  - jtag2_line_reset.sv
  - jtag2_frame_ctrl.sv
  - jtag2_data_path.sv
  - jtag2_tap_top.sv
  # testbench
  - target: test
    files:
      - tb_jtag2_clkgen.sv
      - tb_jtag2_assert.sv
      - tb_jtag2_tap.sv

// File: jtag2_ctrl_if.sv
// frame-phase strobes between frame controller and data path
// all signals are one-tclk levels decoded from the frame state
`timescale 1ns/10ps
`default_nettype none

interface jtag2_ctrl_if;

  // DATA state, instruction group
  logic shift_ir;
  // DATA state, data group
  logic shift_dr;
  // TRN1 of a data-group read
  logic capture_dr;
  // SYNC state of a read
  logic sync_bit;
  // PARITY state
  logic parity_bit;
  // latched read/write bit, 1 = read
  logic read_op;
  // TRN1 of a read, pin turns to output
  logic oe_set;
  // TRN2 or line reset, pin back to input
  logic oe_clr;

  // frame controller side
  modport ctrl (
    output shift_ir, shift_dr, capture_dr, sync_bit,
    output parity_bit, read_op, oe_set, oe_clr
  );

  // data path side
  modport data (
    input shift_ir, shift_dr, capture_dr, sync_bit,
    input parity_bit, read_op, oe_set, oe_clr
  );

endinterface

`default_nettype wire

// File: jtag2_data_path.sv
// data path
// shared shift register for instruction and data group,
// read-back parity, falling-edge pin driver and output enable
`timescale 1ns/10ps
`default_nettype none

module jtag2_data_path #(
  parameter int DR_WIDTH = 32
) (
  input  wire                 tclk,
  input  wire                 trst_b,
  input  wire                 tms_i,
  input  wire  [DR_WIDTH-1:0] rd_data_i,
  output logic [DR_WIDTH-1:0] data_o,
  output logic                tms_o,
  output logic                tms_oe_o,
  jtag2_ctrl_if.data          ctrl_if
);

  // top bit of the instruction inside the shifter
  localparam int IR_MSB = jtag2_pkg::IR_WIDTH_DEF - 1;

  logic [DR_WIDTH-1:0] shift_q;
  logic [DR_WIDTH-1:0] shift_d;
  logic                rd_par_q;
  logic                rd_shift;

  // read-back bit goes out while the data group shifts
  assign rd_shift = ctrl_if.shift_dr && ctrl_if.read_op;

  // ========================================
  // shift register
  // ========================================
  // lsb first, new bits enter at the top
  always_comb begin
    shift_d = shift_q;
    if (ctrl_if.capture_dr) begin
      shift_d = rd_data_i;
    end else if (ctrl_if.shift_dr) begin
      shift_d = {tms_i, shift_q[DR_WIDTH-1:1]};
    end else if (ctrl_if.shift_ir) begin
      // instruction sits in the low bits, rest cleared
      shift_d             = '0;
      shift_d[IR_MSB:0]   = {tms_i, shift_q[IR_MSB:1]};
    end
  end

  always_ff @(posedge tclk) begin
    shift_q <= shift_d;
  end

  assign data_o = shift_q;

  // read parity, 1 xor every bit sent
  always_ff @(posedge tclk) begin
    if (ctrl_if.capture_dr) begin
      rd_par_q <= 1'b1;
    end else if (rd_shift) begin
      rd_par_q <= rd_par_q ^ shift_q[0];
    end
  end

  // ========================================
  // pin output
  // ========================================
  // updated on the falling edge, half a cycle before the host samples
  // idle level is high
  always_ff @(negedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      tms_o <= 1'b1;
    end else if (ctrl_if.sync_bit) begin
      tms_o <= 1'b0;
    end else if (rd_shift) begin
      tms_o <= shift_q[0];
    end else if (ctrl_if.parity_bit && ctrl_if.read_op) begin
      tms_o <= rd_par_q;
    end else begin
      tms_o <= 1'b1;
    end
  end

  // output enable spans SYNC to TRN2 of a read
  // clear has priority so a line reset always releases the pin
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      tms_oe_o <= 1'b0;
    end else if (ctrl_if.oe_clr) begin
      tms_oe_o <= 1'b0;
    end else if (ctrl_if.oe_set) begin
      tms_oe_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: jtag2_frame_ctrl.sv
// frame controller
// frame state machine, read/write latch, group-select shifter,
// data-length counter and write-parity check
// decodes states into data path strobes and host strobes
`timescale 1ns/10ps
`default_nettype none

module jtag2_frame_ctrl #(
  parameter int DR_WIDTH = 32,
  parameter int IR_WIDTH = 8
) (
  input  wire          tclk,
  input  wire          trst_b,
  input  wire          tap_en_i,
  input  wire          tms_i,
  input  wire          line_rst_i,
  output logic         update_ir_o,
  output logic         update_dr_o,
  output logic         capture_dr_o,
  jtag2_ctrl_if.ctrl   ctrl_if
);

  // wide enough for DR_WIDTH-1
  localparam int CNT_W = $clog2(DR_WIDTH);

  jtag2_pkg::frame_state_t state_q;
  jtag2_pkg::frame_state_t state_d;

  logic                 read_q;
  jtag2_pkg::grp_sel_t  rs_q;
  logic                 rs_cnt_q;
  logic [CNT_W-1:0]     data_cnt_q;
  logic                 parity_q;

  logic                 sel_ir;
  logic                 sel_dr;
  logic                 in_data;
  logic                 in_trn1;
  logic                 in_trn2;

  // ========================================
  // state register
  // ========================================
  // line reset wins over every transition
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      state_q <= jtag2_pkg::ST_IDLE;
    end else if (line_rst_i) begin
      state_q <= jtag2_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      jtag2_pkg::ST_IDLE: begin
        // low pin is the start bit
        if (tap_en_i && !tms_i) begin
          state_d = jtag2_pkg::ST_RW;
        end else if (tap_en_i) begin
          state_d = jtag2_pkg::ST_START;
        end
      end
      jtag2_pkg::ST_START: begin
        if (!tms_i) begin
          state_d = jtag2_pkg::ST_RW;
        end
      end
      jtag2_pkg::ST_RW: begin
        state_d = jtag2_pkg::ST_RS;
      end
      jtag2_pkg::ST_RS: begin
        // two select bits
        if (!rs_cnt_q) begin
          state_d = jtag2_pkg::ST_TRN1;
        end
      end
      jtag2_pkg::ST_TRN1: begin
        // reads insert a sync cycle
        if (read_q) begin
          state_d = jtag2_pkg::ST_SYNC;
        end else begin
          state_d = jtag2_pkg::ST_DATA;
        end
      end
      jtag2_pkg::ST_SYNC: begin
        state_d = jtag2_pkg::ST_DATA;
      end
      jtag2_pkg::ST_DATA: begin
        if (data_cnt_q == '0) begin
          state_d = jtag2_pkg::ST_PARITY;
        end
      end
      jtag2_pkg::ST_PARITY: begin
        state_d = jtag2_pkg::ST_TRN2;
      end
      jtag2_pkg::ST_TRN2: begin
        // back to back frames, no idle in between
        state_d = jtag2_pkg::ST_START;
      end
      default: begin
        state_d = jtag2_pkg::ST_IDLE;
      end
    endcase
  end

  // ========================================
  // frame header fields
  // ========================================
  // read/write bit, 1 = read
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      read_q <= 1'b0;
    end else if (state_q == jtag2_pkg::ST_RW) begin
      read_q <= tms_i;
    end
  end

  // group select, shifted in from the top
  // rs_cnt_q marks the first RS cycle
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      rs_q     <= '0;
      rs_cnt_q <= 1'b0;
    end else if (state_q == jtag2_pkg::ST_RW) begin
      rs_cnt_q <= 1'b1;
    end else if (state_q == jtag2_pkg::ST_RS) begin
      rs_q     <= {tms_i, rs_q[1]};
      rs_cnt_q <= 1'b0;
    end
  end

  assign sel_ir  = (rs_q == jtag2_pkg::GRP_IR);
  assign sel_dr  = (rs_q == jtag2_pkg::GRP_DR);
  assign in_data = (state_q == jtag2_pkg::ST_DATA);
  assign in_trn1 = (state_q == jtag2_pkg::ST_TRN1);
  assign in_trn2 = (state_q == jtag2_pkg::ST_TRN2);

  // data length, loaded once the group is known
  // unused groups take the short length
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      data_cnt_q <= '0;
    end else if (in_trn1) begin
      data_cnt_q <= sel_dr ? CNT_W'(DR_WIDTH - 1) : CNT_W'(IR_WIDTH - 1);
    end else if (in_data) begin
      data_cnt_q <= data_cnt_q - 1'b1;
    end
  end

  // ========================================
  // write parity
  // ========================================
  // odd parity over data and parity bit, zero means good
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      parity_q <= 1'b1;
    end else if (state_q == jtag2_pkg::ST_RW) begin
      parity_q <= 1'b1;
    end else if (in_data && (sel_ir || sel_dr)) begin
      parity_q <= parity_q ^ tms_i;
    end else if (state_q == jtag2_pkg::ST_PARITY) begin
      parity_q <= parity_q ^ tms_i;
    end
  end

  // ========================================
  // strobes
  // ========================================
  // updates only for good writes, instruction reads do nothing
  assign update_ir_o  = in_trn2 && sel_ir && !read_q && !parity_q;
  assign update_dr_o  = in_trn2 && sel_dr && !read_q && !parity_q;
  assign capture_dr_o = in_trn1 && sel_dr && read_q;

  assign ctrl_if.shift_ir   = in_data && sel_ir;
  assign ctrl_if.shift_dr   = in_data && sel_dr;
  assign ctrl_if.capture_dr = capture_dr_o;
  assign ctrl_if.sync_bit   = (state_q == jtag2_pkg::ST_SYNC);
  assign ctrl_if.parity_bit = (state_q == jtag2_pkg::ST_PARITY);
  assign ctrl_if.read_op    = read_q;
  assign ctrl_if.oe_set     = in_trn1 && read_q;
  assign ctrl_if.oe_clr     = in_trn2 || line_rst_i;

endmodule

`default_nettype wire

// File: jtag2_line_reset.sv
// line reset detector
// counts consecutive high pin cycles, flags while the count is zero
`timescale 1ns/10ps
`default_nettype none

module jtag2_line_reset #(
  parameter int LINE_RST_LEN = 80
) (
  input  wire  tclk,
  input  wire  trst_b,
  input  wire  tms_i,
  output logic line_rst_o
);

  // room for the reload value itself
  localparam int CNT_W = $clog2(LINE_RST_LEN + 1);

  logic [CNT_W-1:0] rst_cnt_q;

  // down-counter
  // any low cycle restarts the run, zero wraps back to full length
  always_ff @(posedge tclk or negedge trst_b) begin
    if (!trst_b) begin
      rst_cnt_q <= CNT_W'(LINE_RST_LEN);
    end else if (!tms_i) begin
      rst_cnt_q <= CNT_W'(LINE_RST_LEN);
    end else if (rst_cnt_q != '0) begin
      rst_cnt_q <= rst_cnt_q - 1'b1;
    end else begin
      rst_cnt_q <= CNT_W'(LINE_RST_LEN);
    end
  end

  // high during the cycle after LINE_RST_LEN high samples
  assign line_rst_o = (rst_cnt_q == '0);

endmodule

`default_nettype wire

// File: jtag2_pkg.sv
// shared definitions for the two-wire debug TAP slave
// frame state encoding, group-select codes,
// default widths and line-reset run length
`default_nettype none

package jtag2_pkg;

  // ========================================
  // frame states
  // ========================================
  // gray coded, neighbouring states differ in one bit
  typedef enum logic [3:0] {
    ST_IDLE   = 4'b0000,
    ST_START  = 4'b0001,
    ST_RW     = 4'b0011,
    ST_RS     = 4'b0010,
    ST_TRN1   = 4'b0110,
    ST_DATA   = 4'b0111,
    ST_SYNC   = 4'b0101,
    ST_PARITY = 4'b0100,
    ST_TRN2   = 4'b1100
  } frame_state_t;

  // ========================================
  // register group select
  // ========================================
  // first RS bit on the pin lands in bit 0
  typedef logic [1:0] grp_sel_t;

  // instruction group, 8 data cycles
  localparam grp_sel_t GRP_IR = 2'b10;
  // data group, 32 data cycles
  localparam grp_sel_t GRP_DR = 2'b11;
  // codes 00 and 01 run 8 data cycles with no effect

  // ========================================
  // defaults
  // ========================================
  localparam int DR_WIDTH_DEF     = 32;
  localparam int IR_WIDTH_DEF     = 8;
  // high cycles before a line reset is flagged
  localparam int LINE_RST_LEN_DEF = 80;

endpackage

`default_nettype wire

// File: jtag2_stimulus.txt
// columns: op data expected, all hex
// op 1 IR write, 2 DR write, 3 DR read, 4 DR write with bad parity (expected = updates),
// op 5 line reset mid-frame (expected = high cycles until line_rst_o)
1 ffffff3c 0000003c
2 deadbeef deadbeef
3 12345678 12345678
4 cafe0001 00000000
5 00000000 00000051
1 000000a5 000000a5
2 00000000 00000000
3 ffffffff ffffffff
3 80000001 80000001
2 5a5aa5a5 5a5aa5a5
1 00000001 00000001
4 0000ff00 00000000
2 ffffffff ffffffff
1 000000ff 000000ff

// File: jtag2_tap_top.f
jtag2_pkg.sv
jtag2_ctrl_if.sv
jtag2_line_reset.sv
jtag2_frame_ctrl.sv
jtag2_data_path.sv
jtag2_tap_top.sv
tb_jtag2_clkgen.sv
tb_jtag2_assert.sv
tb_jtag2_tap.sv

// File: jtag2_tap_top.sv
// two-wire debug TAP slave, top level
// line reset detector, frame controller and data path
// joined through one control interface
`timescale 1ns/10ps
`default_nettype none

module jtag2_tap_top #(
  parameter int DR_WIDTH     = jtag2_pkg::DR_WIDTH_DEF,
  parameter int IR_WIDTH     = jtag2_pkg::IR_WIDTH_DEF,
  parameter int LINE_RST_LEN = jtag2_pkg::LINE_RST_LEN_DEF
) (
  input  wire                 tclk,
  input  wire                 trst_b,
  input  wire                 tap_en_i,
  input  wire                 tms_i,
  input  wire  [DR_WIDTH-1:0] rd_data_i,
  output logic                tms_o,
  output logic                tms_oe_o,
  output logic                line_rst_o,
  output logic                update_ir_o,
  output logic                update_dr_o,
  output logic                capture_dr_o,
  output logic [DR_WIDTH-1:0] data_o
);

  // frame phase strobes
  jtag2_ctrl_if u_ctrl_if ();

  // ========================================
  // line reset
  // ========================================
  jtag2_line_reset #(
    .LINE_RST_LEN (LINE_RST_LEN)
  ) u_line_reset (
    .tclk       (tclk),
    .trst_b     (trst_b),
    .tms_i      (tms_i),
    .line_rst_o (line_rst_o)
  );

  // ========================================
  // frame control and data
  // ========================================
  jtag2_frame_ctrl #(
    .DR_WIDTH (DR_WIDTH),
    .IR_WIDTH (IR_WIDTH)
  ) u_frame_ctrl (
    .tclk         (tclk),
    .trst_b       (trst_b),
    .tap_en_i     (tap_en_i),
    .tms_i        (tms_i),
    .line_rst_i   (line_rst_o),
    .update_ir_o  (update_ir_o),
    .update_dr_o  (update_dr_o),
    .capture_dr_o (capture_dr_o),
    .ctrl_if      (u_ctrl_if.ctrl)
  );

  jtag2_data_path #(
    .DR_WIDTH (DR_WIDTH)
  ) u_data_path (
    .tclk      (tclk),
    .trst_b    (trst_b),
    .tms_i     (tms_i),
    .rd_data_i (rd_data_i),
    .data_o    (data_o),
    .tms_o     (tms_o),
    .tms_oe_o  (tms_oe_o),
    .ctrl_if   (u_ctrl_if.data)
  );

endmodule

`default_nettype wire

// File: tb_jtag2_assert.sv
// bound checks on the TAP top level
// update strobe exclusivity, output enable after line reset,
// capture pulse width
`timescale 1ns/10ps
`default_nettype none

module tb_jtag2_assert (
  input wire tclk,
  input wire trst_b,
  input wire update_ir_i,
  input wire update_dr_i,
  input wire capture_dr_i,
  input wire line_rst_i,
  input wire tms_oe_i
);

  // count of failed properties
  int fail_cnt = 0;

  // only one group can finish a frame
  a_update_excl: assert property (
    @(posedge tclk) disable iff (!trst_b) !(update_ir_i && update_dr_i)
  ) else begin
    fail_cnt++;
    $error("update_ir_o and update_dr_o high in the same cycle");
  end

  // line reset releases the pin on the next edge
  a_oe_after_lrst: assert property (
    @(posedge tclk) disable iff (!trst_b) line_rst_i |=> !tms_oe_i
  ) else begin
    fail_cnt++;
    $error("tms_oe_o still high after line_rst_o");
  end

  // capture lasts exactly one TRN1 cycle
  a_capture_pulse: assert property (
    @(posedge tclk) disable iff (!trst_b) capture_dr_i |=> !capture_dr_i
  ) else begin
    fail_cnt++;
    $error("capture_dr_o longer than one cycle");
  end

endmodule

`default_nettype wire

// File: tb_jtag2_clkgen.sv
// testbench clock and reset generator
// free running tclk, trst_b held low for a few cycles
`timescale 1ns/10ps
`default_nettype none

module tb_jtag2_clkgen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 4
) (
  output logic tclk,
  output logic trst_b
);

  initial begin
    tclk = 1'b0;
    forever #(PERIOD_NS / 2) tclk = ~tclk;
  end

  // release just after a rising edge
  initial begin
    trst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge tclk);
    #1;
    trst_b = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_jtag2_tap.sv
// testbench top for the two-wire debug TAP slave
// plays frames from the stimulus file bit by bit,
// counts strobes and collects the read-back bits on tms_o
`timescale 1ns/10ps
`default_nettype none

module tb_jtag2_tap;

  localparam int NUM_VEC    = 14;
  localparam int DR_W       = 32;
  localparam int IR_W       = 8;
  localparam int WAIT_LIMIT = 60;
  localparam int LRST_LIMIT = 120;

  // operation codes of the stimulus file
  localparam logic [31:0] OP_IR_WR   = 32'd1;
  localparam logic [31:0] OP_DR_WR   = 32'd2;
  localparam logic [31:0] OP_DR_RD   = 32'd3;
  localparam logic [31:0] OP_BAD_PAR = 32'd4;
  localparam logic [31:0] OP_LRST    = 32'd5;

  logic            tclk;
  logic            trst_b;
  logic            tap_en_i;
  logic            tms_i;
  logic [DR_W-1:0] rd_data_i;
  logic            tms_o;
  logic            tms_oe_o;
  logic            line_rst_o;
  logic            update_ir_o;
  logic            update_dr_o;
  logic            capture_dr_o;
  logic [DR_W-1:0] data_o;

  // three words per vector: op, data, expected
  logic [31:0] stim_mem [0:3*NUM_VEC-1];
  logic [31:0] rd_word;
  logic [31:0] upd_word;
  logic [31:0] op;
  logic [31:0] word;
  logic [31:0] exp_word;
  logic        readback [$];
  logic        seen_oe;
  int          n_upd_ir;
  int          n_upd_dr;
  int          n_capture;
  int          n_line_rst;
  int          vec;
  int          bit_idx;
  int          cycles;

  tb_jtag2_clkgen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (4)
  ) u_clkgen (
    .tclk   (tclk),
    .trst_b (trst_b)
  );

  jtag2_tap_top u_dut (
    .tclk         (tclk),
    .trst_b       (trst_b),
    .tap_en_i     (tap_en_i),
    .tms_i        (tms_i),
    .rd_data_i    (rd_data_i),
    .tms_o        (tms_o),
    .tms_oe_o     (tms_oe_o),
    .line_rst_o   (line_rst_o),
    .update_ir_o  (update_ir_o),
    .update_dr_o  (update_dr_o),
    .capture_dr_o (capture_dr_o),
    .data_o       (data_o)
  );

  bind jtag2_tap_top tb_jtag2_assert u_assert (
    .tclk         (tclk),
    .trst_b       (trst_b),
    .update_ir_i  (update_ir_o),
    .update_dr_i  (update_dr_o),
    .capture_dr_i (capture_dr_o),
    .line_rst_i   (line_rst_o),
    .tms_oe_i     (tms_oe_o)
  );

  // ========================================
  // helpers
  // ========================================
  task stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_on_error("value mismatch");
    end
  endtask

  // 1 xor the low width bits
  function automatic logic odd_parity(input logic [31:0] w, input int width);
    logic p;
    int   k;
    p = 1'b1;
    for (k = 0; k < width; k++) begin
      p = p ^ w[k];
    end
    return p;
  endfunction

  task clear_counts;
    n_upd_ir   = 0;
    n_upd_dr   = 0;
    n_capture  = 0;
    n_line_rst = 0;
    upd_word   = '0;
    readback.delete();
  endtask

  // one tclk cycle, pin driven after the rising edge
  // outputs looked at after the falling edge, where all are settled
  task tick(input logic pin);
    @(posedge tclk);
    #1;
    tms_i     = pin;
    rd_data_i = rd_word;
    @(negedge tclk);
    #1;
    if (update_ir_o) begin
      n_upd_ir = n_upd_ir + 1;
      upd_word = data_o;
    end
    if (update_dr_o) begin
      n_upd_dr = n_upd_dr + 1;
      upd_word = data_o;
    end
    if (capture_dr_o) n_capture = n_capture + 1;
    if (line_rst_o) n_line_rst = n_line_rst + 1;
    if (tms_oe_o) readback.push_back(tms_o);
    if (u_dut.u_assert.fail_cnt != 0) begin
      stop_on_error("a bound assertion on the DUT failed");
    end
  endtask

  // start, rw, two select bits (bit 0 first), turnaround
  task send_header(input logic is_read, input logic [1:0] grp);
    tick(1'b0);
    tick(is_read);
    tick(grp[0]);
    tick(grp[1]);
    tick(1'b1);
  endtask

  task run_write(input logic [1:0] grp, input int width, input logic [31:0] wdata,
                 input logic bad_par);
    send_header(1'b0, grp);
    for (bit_idx = 0; bit_idx < width; bit_idx++) begin
      tick(wdata[bit_idx]);
    end
    tick(odd_parity(wdata, width) ^ bad_par);
  endtask

  task wait_update;
    cycles = 0;
    while ((n_upd_ir + n_upd_dr) == 0 && cycles < WAIT_LIMIT) begin
      tick(1'b1);
      cycles++;
    end
    if ((n_upd_ir + n_upd_dr) == 0) begin
      stop_on_error("timed out waiting for an update strobe");
    end
    // extra cycle catches a pulse longer than one cycle
    tick(1'b1);
  endtask

  // host keeps the pin high while the slave drives it
  task run_read(input logic [31:0] rdata, input logic [31:0] exp);
    rd_word = rdata;
    send_header(1'b1, jtag2_pkg::GRP_DR);
    cycles  = 0;
    seen_oe = 1'b0;
    while (!(seen_oe && !tms_oe_o) && cycles < WAIT_LIMIT) begin
      tick(1'b1);
      if (tms_oe_o) seen_oe = 1'b1;
      cycles++;
    end
    if (!seen_oe || tms_oe_o) begin
      stop_on_error("timed out waiting for the read-back window to close");
    end
    check("capture_dr_o pulses", n_capture, 1);
    // sync, data bits, parity, turnaround
    check("read-back length", readback.size(), DR_W + 3);
    check("tms_o sync", readback[0], 1'b0);
    for (bit_idx = 0; bit_idx < DR_W; bit_idx++) begin
      check($sformatf("tms_o bit %0d", bit_idx), readback[bit_idx+1], exp[bit_idx]);
    end
    check("tms_o parity", readback[DR_W+1], odd_parity(exp, DR_W));
    check("tms_o trn2", readback[DR_W+2], 1'b1);
  endtask

  // DR write abandoned after four bits, odd count of ones
  // so the frame that finishes under the high run fails parity
  task run_line_reset(input logic [31:0] exp_run);
    send_header(1'b0, jtag2_pkg::GRP_DR);
    tick(1'b1);
    tick(1'b1);
    tick(1'b1);
    tick(1'b0);
    cycles = 0;
    while (n_line_rst == 0 && cycles < LRST_LIMIT) begin
      tick(1'b1);
      cycles++;
    end
    if (n_line_rst == 0) stop_on_error("timed out waiting for line reset");
    check("line_rst_o high cycles", cycles, exp_run);
    tick(1'b1);
    check("line_rst_o pulses", n_line_rst, 1);
    check("update_dr_o pulses", n_upd_dr, 0);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    tap_en_i  = 1'b0;
    tms_i     = 1'b1;
    rd_data_i = '0;
    rd_word   = '0;
    clear_counts();
    $readmemh("jtag2_stimulus.txt", stim_mem);

    cycles = 0;
    while (trst_b !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge tclk);
      cycles++;
    end
    if (trst_b !== 1'b1) stop_on_error("reset was never released");
    #1;
    tap_en_i = 1'b1;

    // idle levels after reset
    @(negedge tclk);
    #1;
    check("tms_o", tms_o, 1'b1);
    check("tms_oe_o", tms_oe_o, 1'b0);
    check("update_ir_o", update_ir_o, 1'b0);
    check("update_dr_o", update_dr_o, 1'b0);
    check("capture_dr_o", capture_dr_o, 1'b0);

    for (vec = 0; vec < NUM_VEC; vec++) begin
      op       = stim_mem[3*vec];
      word     = stim_mem[3*vec+1];
      exp_word = stim_mem[3*vec+2];
      if ((^{op, word, exp_word}) === 1'bx) begin
        stop_on_error("stimulus file missing or too short");
      end
      clear_counts();
      case (op)
        OP_IR_WR: begin
          run_write(jtag2_pkg::GRP_IR, IR_W, word, 1'b0);
          wait_update();
          check("update_ir_o pulses", n_upd_ir, 1);
          check("update_dr_o pulses", n_upd_dr, 0);
          check("data_o", upd_word, exp_word);
        end
        OP_DR_WR: begin
          run_write(jtag2_pkg::GRP_DR, DR_W, word, 1'b0);
          wait_update();
          check("update_dr_o pulses", n_upd_dr, 1);
          check("update_ir_o pulses", n_upd_ir, 0);
          check("data_o", upd_word, exp_word);
        end
        OP_DR_RD: begin
          run_read(word, exp_word);
          check("update_ir_o pulses", n_upd_ir, 0);
          check("update_dr_o pulses", n_upd_dr, 0);
        end
        OP_BAD_PAR: begin
          run_write(jtag2_pkg::GRP_DR, DR_W, word, 1'b1);
          // TRN2 and two cycles in START
          repeat (3) tick(1'b1);
          check("update_dr_o pulses", n_upd_dr, exp_word);
          check("update_ir_o pulses", n_upd_ir, 0);
        end
        OP_LRST: begin
          run_line_reset(exp_word);
        end
        default: begin
          stop_on_error("unknown operation code in stimulus file");
        end
      endcase
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
